// ==== hdl/piso_cfg_pkg.sv ====
// sizing constants for the message serializer, imported by every RTL block and the testbench
`default_nettype none

package piso_cfg_pkg;

  // width of one word as it leaves on the output channel
  localparam int WORD_W = 16;

  // largest message the producer may present, counted in words
  localparam int MAX_WORDS = 4;

  // width of the length code and of the core's word index
  // the safe log2 keeps one bit even if the message shrinks to a single word
  localparam int LEN_W = (MAX_WORDS > 1) ? $clog2(MAX_WORDS) : 1;

endpackage : piso_cfg_pkg

`default_nettype wire

// ==== hdl/piso_msg_pkg.sv ====
// payload types of the serializer (word, whole message, length code), shared by all blocks
`default_nettype none

package piso_msg_pkg;

  import piso_cfg_pkg::*;

  // one word as it travels on the output channel
  typedef logic [WORD_W-1:0] word_t;

  // a whole message in which word zero sits in the lowest slot and goes out first
  // slots above the length code are carried along but never sent
  typedef word_t [MAX_WORDS-1:0] msg_t;

  // length code, which is the number of words minus one
  // so a value of zero means a single-word message
  typedef logic [LEN_W-1:0] len_t;

endpackage : piso_msg_pkg

`default_nettype wire

// ==== hdl/msg_rx_4ph.sv ====
// receives a message over four-phase req/ack and holds it for the serializer core in the top
`timescale 1ns/10ps
`default_nettype none

module msg_rx_4ph
  import piso_msg_pkg::*;
(
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic in_req_i,
  input  msg_t in_msg_i,
  input  len_t in_len_i,
  input  logic msg_ready_and_i,
  output logic in_ack_o,
  output logic msg_v_o,
  output msg_t msg_data_o,
  output len_t msg_len_o
);

  // empty waits for a request, hold offers the message to the core,
  // ack keeps in_ack_o up until the producer drops its request
  typedef enum logic [1:0] {RX_EMPTY, RX_HOLD, RX_ACK} rx_state_e;

  rx_state_e state_r;
  rx_state_e state_nxt;
  logic      capture;
  msg_t      msg_r;
  len_t      len_r;

  // a new request is only taken while nothing is held
  assign capture = (state_r == RX_EMPTY) && in_req_i;

  always_comb
  begin
    state_nxt = state_r;
    case (state_r)
      RX_EMPTY:
      begin
        if (capture)
        begin
          state_nxt = RX_HOLD;
        end
      end
      // the core raises ready_and together with the last word it sends
      RX_HOLD:
      begin
        if (msg_ready_and_i)
        begin
          state_nxt = RX_ACK;
        end
      end
      // the four-phase return waits for the producer to release the request
      RX_ACK:
      begin
        if (!in_req_i)
        begin
          state_nxt = RX_EMPTY;
        end
      end
      default:
      begin
        state_nxt = RX_EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r <= RX_EMPTY;
    end
    else
    begin
      state_r <= state_nxt;
    end
  end

  // message and length stay frozen from capture until the next request,
  // which keeps the core's input constant for the whole serialization
  always_ff @(posedge clk_i)
  begin
    if (capture)
    begin
      msg_r <= in_msg_i;
      len_r <= in_len_i;
    end
  end

  assign msg_v_o    = (state_r == RX_HOLD);
  assign in_ack_o   = (state_r == RX_ACK);
  assign msg_data_o = msg_r;
  assign msg_len_o  = len_r;

endmodule : msg_rx_4ph

`default_nettype wire

// ==== hdl/piso_passthrough_dynamic.sv ====
// core that walks a held message word by word between the receiver and the transmitter
`timescale 1ns/10ps
`default_nettype none

module piso_passthrough_dynamic
  import piso_cfg_pkg::*;
  import piso_msg_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  v_i,
  input  msg_t  data_i,
  input  len_t  len_i,
  input  logic  ready_and_i,
  output logic  ready_and_o,
  output logic  v_o,
  output word_t data_o,
  output logic  len_ready_o
);

  // index of the word currently on data_o
  len_t count_r;

  // length code as sampled with the first word of the message
  len_t len_r;

  logic is_zero_cnt;
  logic is_last_cnt;
  logic is_zero_len;
  logic len_en;
  logic clear_cnt;
  logic up_cnt;
  logic xfer;

  // a word moves downstream whenever both sides agree
  assign xfer = v_o & ready_and_i;

  assign is_zero_cnt = (count_r == '0);

  // the last word of a multi-word message is reached when the index meets the stored length,
  // index zero is excluded so a stale len_r from the previous message cannot fire early
  assign is_last_cnt = ~is_zero_cnt & (count_r == len_r);

  // a single-word message ends on its first transfer, so use the live length here
  assign is_zero_len = ready_and_i & is_zero_cnt & (len_i == '0);

  // the length register loads only alongside the first word
  assign len_en = xfer & is_zero_cnt;

  // completion resets the index, otherwise each transfer moves it on
  assign clear_cnt = v_i & ready_and_o;
  assign up_cnt    = xfer & ~clear_cnt;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      count_r <= '0;
    end
    else if (clear_cnt)
    begin
      count_r <= '0;
    end
    else if (up_cnt)
    begin
      count_r <= count_r + LEN_W'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      len_r <= '0;
    end
    else if (len_en)
    begin
      len_r <= len_i;
    end
  end

  // valid goes straight across with no buffering
  assign v_o = v_i;

  // upstream sees ready only in the cycle its last word is taken
  assign ready_and_o = (ready_and_i & is_last_cnt) | is_zero_len;

  // index zero means the word now on data_o opens a message
  assign len_ready_o = is_zero_cnt;

  // the upstream holds data_i stable, so the word select is glitch free per message
  assign data_o = data_i[count_r];

endmodule : piso_passthrough_dynamic

`default_nettype wire

// ==== hdl/word_tx_4ph.sv ====
// registers each serialized word with its first flag and offers it over four-phase req/ack
`timescale 1ns/10ps
`default_nettype none

module word_tx_4ph
  import piso_msg_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  v_i,
  input  word_t data_i,
  input  logic  first_i,
  input  logic  out_ack_i,
  output logic  ready_and_o,
  output logic  out_req_o,
  output word_t out_word_o,
  output logic  out_first_o
);

  // idle accepts a word, req holds out_req_o up until ack,
  // ack_low waits for the consumer to release its ack
  typedef enum logic [1:0] {TX_IDLE, TX_REQ, TX_ACK_LOW} tx_state_e;

  tx_state_e state_r;
  tx_state_e state_nxt;
  logic      capture;
  word_t     word_r;
  logic      first_r;

  // only one word is in flight, so ready simply means idle
  assign ready_and_o = (state_r == TX_IDLE);
  assign capture     = v_i & ready_and_o;

  always_comb
  begin
    state_nxt = state_r;
    case (state_r)
      TX_IDLE:
      begin
        if (capture)
        begin
          state_nxt = TX_REQ;
        end
      end
      TX_REQ:
      begin
        if (out_ack_i)
        begin
          state_nxt = TX_ACK_LOW;
        end
      end
      // the handshake is complete only once ack is back low
      TX_ACK_LOW:
      begin
        if (!out_ack_i)
        begin
          state_nxt = TX_IDLE;
        end
      end
      default:
      begin
        state_nxt = TX_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state_r <= TX_IDLE;
    end
    else
    begin
      state_r <= state_nxt;
    end
  end

  // word and flag stay put while the request is up and until the next capture
  always_ff @(posedge clk_i)
  begin
    if (capture)
    begin
      word_r  <= data_i;
      first_r <= first_i;
    end
  end

  assign out_req_o   = (state_r == TX_REQ);
  assign out_word_o  = word_r;
  assign out_first_o = first_r;

endmodule : word_tx_4ph

`default_nettype wire

// ==== hdl/piso_serializer_top.sv ====
// top of the message serializer with a four-phase message input and a four-phase word output
`timescale 1ns/10ps
`default_nettype none

module piso_serializer_top
  import piso_msg_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_n_i,
  input  logic  in_req_i,
  input  msg_t  in_msg_i,
  input  len_t  in_len_i,
  input  logic  out_ack_i,
  output logic  in_ack_o,
  output logic  out_req_o,
  output word_t out_word_o,
  output logic  out_first_o
);

  // the receiver holds the message stable until the core signals done
  logic msg_v;
  msg_t msg_data;
  len_t msg_len;
  logic msg_ready_and;

  // the core hands one word to the transmitter per valid and ready_and cycle
  logic  word_v;
  word_t word_data;
  logic  word_first;
  logic  word_ready_and;

  msg_rx_4ph msg_rx_4ph_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .in_req_i        (in_req_i),
    .in_msg_i        (in_msg_i),
    .in_len_i        (in_len_i),
    .msg_ready_and_i (msg_ready_and),
    .in_ack_o        (in_ack_o),
    .msg_v_o         (msg_v),
    .msg_data_o      (msg_data),
    .msg_len_o       (msg_len)
  );

  // length comes from the receiver's held copy and is sampled on the first word
  piso_passthrough_dynamic piso_passthrough_dynamic_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .v_i         (msg_v),
    .data_i      (msg_data),
    .len_i       (msg_len),
    .ready_and_i (word_ready_and),
    .ready_and_o (msg_ready_and),
    .v_o         (word_v),
    .data_o      (word_data),
    .len_ready_o (word_first)
  );

  word_tx_4ph word_tx_4ph_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .v_i         (word_v),
    .data_i      (word_data),
    .first_i     (word_first),
    .out_ack_i   (out_ack_i),
    .ready_and_o (word_ready_and),
    .out_req_o   (out_req_o),
    .out_word_o  (out_word_o),
    .out_first_o (out_first_o)
  );

endmodule : piso_serializer_top

`default_nettype wire

// ==== include/piso_tb_vectors.svh ====
// message table for the serializer testbench, included in its module and applied row by row
`ifndef PISO_TB_VECTORS_SVH
`define PISO_TB_VECTORS_SVH

// how the consumer answers out_req_o for every word of a row
localparam int DLY_ZERO   = 0;
localparam int DLY_FIXED  = 1;
localparam int DLY_RANDOM = 2;

// hold-off in cycles for the fixed mode
localparam int FIXED_DLY = 3;

// random hold-off is drawn from zero up to one less than this
localparam int RAND_DLY_SPAN = 6;

localparam int NUM_VEC = 8;

// word zero of each row is sent first
// slots past the length code hold marker values that must never reach the output
word_t vec_words [NUM_VEC][MAX_WORDS];
len_t  vec_len   [NUM_VEC];
int    vec_mode  [NUM_VEC];

task automatic set_row(input int idx, input word_t w0, input word_t w1, input word_t w2,
                       input word_t w3, input len_t len, input int mode);
begin
  vec_words[idx][0] = w0;
  vec_words[idx][1] = w1;
  vec_words[idx][2] = w2;
  vec_words[idx][3] = w3;
  vec_len[idx]      = len;
  vec_mode[idx]     = mode;
end
endtask

// each row gives words 0 to 3, the length code and the consumer delay mode
task automatic load_vectors();
begin
  set_row(0, 16'h1100, 16'hd001, 16'hd002, 16'hd003, 2'd0, DLY_ZERO);
  set_row(1, 16'h2100, 16'h2101, 16'h2102, 16'h2103, 2'd3, DLY_ZERO);
  // rows 2 and 3 go out back to back with a slow but steady consumer
  set_row(2, 16'h3100, 16'h3101, 16'hd021, 16'hd022, 2'd1, DLY_FIXED);
  set_row(3, 16'h4100, 16'h4101, 16'h4102, 16'hd031, 2'd2, DLY_FIXED);
  // the rest runs against a consumer with random hold-off
  set_row(4, 16'h5a5a, 16'ha5a5, 16'hffff, 16'h0000, 2'd3, DLY_RANDOM);
  set_row(5, 16'h6100, 16'h6101, 16'h6102, 16'hd051, 2'd2, DLY_RANDOM);
  set_row(6, 16'h7100, 16'hd061, 16'hd062, 16'hd063, 2'd0, DLY_RANDOM);
  set_row(7, 16'h8100, 16'h8101, 16'hd071, 16'hd072, 2'd1, DLY_RANDOM);
end
endtask

`endif

// ==== tb/piso_serializer_tb.sv ====
// testbench that sends the message table over the input channel and checks the word stream
`timescale 1ns/10ps
`default_nettype none

module piso_serializer_tb
  import piso_cfg_pkg::*;
  import piso_msg_pkg::*;
();

  localparam int CLK_HALF     = 20;
  localparam int RST_CYCLES   = 8;
  localparam int WAIT_LIMIT   = 400;
  localparam int QUIET_CYCLES = 20;

  logic  clk_i;
  logic  rst_n_i;
  logic  in_req_i;
  msg_t  in_msg_i;
  len_t  in_len_i;
  logic  out_ack_i;
  logic  in_ack_o;
  logic  out_req_o;
  word_t out_word_o;
  logic  out_first_o;

  // set once the producer raises its first request
  bit   req_started;
  bit   consumer_done;
  // counts the words the DUT has offered, one per rise of out_req_o
  int   offered_words;
  // words that must have been offered by the time in_ack_o rises
  int   acked_words;
  int   acks_seen;
  int   total_words;
  int   seed_val;
  bit   out_req_q;
  bit   in_ack_q;
  msg_t msg_next;

  `include "piso_tb_vectors.svh"

  piso_serializer_top piso_serializer_top_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_req_i    (in_req_i),
    .in_msg_i    (in_msg_i),
    .in_len_i    (in_len_i),
    .out_ack_i   (out_ack_i),
    .in_ack_o    (in_ack_o),
    .out_req_o   (out_req_o),
    .out_word_o  (out_word_o),
    .out_first_o (out_first_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  task automatic fail_run(input string why);
  begin
    $display("test failed");
    $display("%s", why);
    $fatal(1);
  end
  endtask

  // all waits sample on the falling edge, half a cycle away from any driven change
  task automatic wait_reset_release();
    int cycles;
  begin
    cycles = 0;
    do
    begin
      @(negedge clk_i);
      cycles++;
    end
    while ((rst_n_i !== 1'b1) && (cycles < WAIT_LIMIT));
    assert (rst_n_i === 1'b1)
    else fail_run("reset was never released");
  end
  endtask

  task automatic wait_in_ack(input logic level);
    int cycles;
  begin
    cycles = 0;
    do
    begin
      @(negedge clk_i);
      cycles++;
    end
    while ((in_ack_o !== level) && (cycles < WAIT_LIMIT));
    assert (in_ack_o === level)
    else fail_run($sformatf("in_ack_o did not go to %0b within %0d cycles", level, WAIT_LIMIT));
  end
  endtask

  task automatic wait_out_req(input logic level);
    int cycles;
  begin
    cycles = 0;
    do
    begin
      @(negedge clk_i);
      cycles++;
    end
    while ((out_req_o !== level) && (cycles < WAIT_LIMIT));
    assert (out_req_o === level)
    else fail_run($sformatf("out_req_o did not go to %0b within %0d cycles", level, WAIT_LIMIT));
  end
  endtask

  task automatic wait_consumer_done();
    int cycles;
  begin
    cycles = 0;
    while (!consumer_done && (cycles < WAIT_LIMIT))
    begin
      @(negedge clk_i);
      cycles++;
    end
    assert (consumer_done)
    else fail_run("the consumer did not receive all expected words in time");
  end
  endtask

  // after the last message nothing may move on either channel
  task automatic check_quiet();
  begin
    repeat (QUIET_CYCLES)
    begin
      @(negedge clk_i);
      assert (out_req_o === 1'b0)
      else fail_run("an extra word was offered after the last expected word");
      assert (in_ack_o === 1'b0)
      else fail_run("in_ack_o rose with no request pending");
    end
  end
  endtask

  function automatic int ack_delay(input int mode);
  begin
    case (mode)
      DLY_FIXED:  return FIXED_DLY;
      DLY_RANDOM: return $urandom % RAND_DLY_SPAN;
      default:    return 0;
    endcase
  end
  endfunction

  // the producer runs one four-phase transfer per table row
  initial
  begin
    rst_n_i   = 1'b0;
    in_req_i  = 1'b0;
    in_msg_i  = '0;
    in_len_i  = '0;
    out_ack_i = 1'b0;
    load_vectors();
    total_words = 0;
    for (int r = 0; r < NUM_VEC; r++)
    begin
      total_words += int'(vec_len[r]) + 1;
    end
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // a few idle cycles so the outputs can be seen quiet before any request
    repeat (4) @(posedge clk_i);
    for (int r = 0; r < NUM_VEC; r++)
    begin
      for (int i = 0; i < MAX_WORDS; i++)
      begin
        msg_next[i] = vec_words[r][i];
      end
      // data first, request one edge later
      @(posedge clk_i);
      in_msg_i <= msg_next;
      in_len_i <= vec_len[r];
      @(posedge clk_i);
      in_req_i <= 1'b1;
      req_started = 1'b1;
      wait_in_ack(1'b1);
      @(posedge clk_i);
      in_req_i <= 1'b0;
      wait_in_ack(1'b0);
    end
    wait_consumer_done();
    check_quiet();
    if ((acks_seen == NUM_VEC) && (offered_words == total_words))
    begin
      $display("test passed");
      $finish;
    end
    else
    begin
      fail_run($sformatf("saw %0d acks and %0d words, expected %0d and %0d",
                         acks_seen, offered_words, NUM_VEC, total_words));
    end
  end

  // the consumer expects words zero up to the length code of each row, first flag on word zero only
  initial
  begin : consumer
    int delay;
    // seeds the generator that draws the random hold-off in this process
    seed_val = $urandom(46269);
    wait_reset_release();
    for (int r = 0; r < NUM_VEC; r++)
    begin
      for (int i = 0; i <= int'(vec_len[r]); i++)
      begin
        wait_out_req(1'b1);
        assert (out_word_o === vec_words[r][i])
        else fail_run($sformatf(
          "mismatch out_word_o: got 0x%h expected 0x%h (message %0d word %0d)",
          out_word_o, vec_words[r][i], r, i));
        assert (out_first_o === (i == 0))
        else fail_run($sformatf(
          "mismatch out_first_o: got 0x%h expected 0x%h (message %0d word %0d)",
          out_first_o, (i == 0), r, i));
        delay = ack_delay(vec_mode[r]);
        repeat (delay) @(posedge clk_i);
        @(posedge clk_i);
        out_ack_i <= 1'b1;
        wait_out_req(1'b0);
        @(posedge clk_i);
        out_ack_i <= 1'b0;
      end
    end
    consumer_done = 1'b1;
  end

  // the monitor wants quiet outputs before the first request, and in_ack_o only after the last word
  always @(negedge clk_i)
  begin
    if (rst_n_i)
    begin
      if (!req_started)
      begin
        assert ((in_ack_o === 1'b0) && (out_req_o === 1'b0))
        else fail_run("in_ack_o or out_req_o went high before the first request");
      end
      if (out_req_o && !out_req_q)
      begin
        offered_words++;
      end
      if (in_ack_o && !in_ack_q)
      begin
        assert (acks_seen < NUM_VEC)
        else fail_run("in_ack_o rose more often than messages were sent");
        if (acks_seen < NUM_VEC)
        begin
          acked_words += int'(vec_len[acks_seen]) + 1;
        end
        // the last word of this message has to be with the output side already
        assert (offered_words == acked_words)
        else fail_run($sformatf("mismatch offered words at in_ack_o: got 0x%h expected 0x%h",
                                offered_words, acked_words));
        acks_seen++;
      end
      out_req_q = out_req_o;
      in_ack_q  = in_ack_o;
    end
  end

endmodule : piso_serializer_tb

`default_nettype wire

// ==== sim.f ====
+incdir+include
hdl/piso_cfg_pkg.sv
hdl/piso_msg_pkg.sv
hdl/msg_rx_4ph.sv
hdl/piso_passthrough_dynamic.sv
hdl/word_tx_4ph.sv
hdl/piso_serializer_top.sv
tb/piso_serializer_tb.sv
